/* src/uart_pkg.sv */
package uart_pkg;

	// serial timing
	localparam int CLKS_PER_BIT = 8;	// short bit time for simulation
	localparam int DATA_BITS = 8;	// 8N1 frames only

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam int IDX_W = $clog2(DATA_BITS);

	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);	// last cycle of a bit
	localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(CLKS_PER_BIT / 2 - 1);	// middle of a bit
	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(DATA_BITS - 1);	// msb of the byte

	typedef logic [DATA_BITS-1:0] byte_t;

	// word address from paddr[2]
	typedef enum logic {
		REG_RXDATA = 1'b0,	// rx byte, rx flag, overrun
		REG_TXDATA = 1'b1	// write sends, read gives busy
	} reg_addr_e;

	// shared by receiver and transmitter
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_START,
		ST_DATA,
		ST_STOP
	} serial_state_e;

endpackage

/* src/uart_rx.sv */
`timescale 1ns/100ps

module uart_rx (
	input  logic clk,
	input  logic reset_n,
	input  logic rxd,
	output logic rx_valid,
	output uart_pkg::byte_t rx_data
);

	logic rxd_meta;	// first sync stage
	logic rxd_sync;
	uart_pkg::serial_state_e state;
	logic [uart_pkg::CNT_W-1:0] cnt;	// cycles inside current bit
	logic [uart_pkg::IDX_W-1:0] idx;	// data bit number
	logic sample_data;

	// sync flops start at the idle line level
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
		end
	end

	assign sample_data = (state == uart_pkg::ST_DATA) && (cnt == uart_pkg::CNT_LAST);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= uart_pkg::ST_IDLE;
			cnt <= '0;
			idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;	// strobe by default low
			case (state)
				uart_pkg::ST_IDLE: begin
					cnt <= '0;
					if (!rxd_sync)
						state <= uart_pkg::ST_START;	// falling edge seen
				end
				uart_pkg::ST_START: begin
					if (cnt == uart_pkg::CNT_HALF) begin
						cnt <= '0;
						idx <= '0;
						// glitch shorter than half a bit goes back to idle
						state <= rxd_sync ? uart_pkg::ST_IDLE : uart_pkg::ST_DATA;
					end else
						cnt <= cnt + 1'b1;
				end
				uart_pkg::ST_DATA: begin
					if (cnt == uart_pkg::CNT_LAST) begin	// mid data bit
						cnt <= '0;
						if (idx == uart_pkg::IDX_LAST)
							state <= uart_pkg::ST_STOP;
						else
							idx <= idx + 1'b1;
					end else
						cnt <= cnt + 1'b1;
				end
				uart_pkg::ST_STOP: begin
					if (cnt == uart_pkg::CNT_LAST) begin	// mid stop bit
						cnt <= '0;
						rx_valid <= rxd_sync;	// framing error drops the byte
						state <= uart_pkg::ST_IDLE;
					end else
						cnt <= cnt + 1'b1;
				end
				default: state <= uart_pkg::ST_IDLE;
			endcase
		end
	end

	// lsb arrives first so shift in from the top
	always_ff @(posedge clk) begin
		if (sample_data)
			rx_data <= {rxd_sync, rx_data[uart_pkg::DATA_BITS-1:1]};
	end

	a_rx_valid_single: assert property (@(posedge clk) disable iff (!reset_n)
		rx_valid |=> !rx_valid);

endmodule

/* src/uart_tx.sv */
`timescale 1ns/100ps

module uart_tx (
	input  logic clk,
	input  logic reset_n,
	input  logic tx_start,
	input  uart_pkg::byte_t tx_data,
	output logic tx_busy,
	output logic txd
);

	uart_pkg::serial_state_e state;
	logic [uart_pkg::CNT_W-1:0] cnt;	// cycles inside current bit
	logic [uart_pkg::IDX_W-1:0] idx;	// data bit number
	uart_pkg::byte_t shift;	// bit 0 is on the line during ST_DATA
	logic bit_end;

	assign bit_end = (cnt == uart_pkg::CNT_LAST);
	assign tx_busy = (state != uart_pkg::ST_IDLE);

	always_comb begin
		case (state)
			uart_pkg::ST_START: txd = 1'b0;
			uart_pkg::ST_DATA: txd = shift[0];
			default: txd = 1'b1;	// idle and stop
		endcase
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state <= uart_pkg::ST_IDLE;
			cnt <= '0;
			idx <= '0;
		end else begin
			case (state)
				uart_pkg::ST_IDLE: begin
					cnt <= '0;
					if (tx_start)
						state <= uart_pkg::ST_START;	// start bit from next cycle
				end
				uart_pkg::ST_START: begin
					cnt <= cnt + 1'b1;	// wraps to zero on bit_end
					idx <= '0;
					if (bit_end)
						state <= uart_pkg::ST_DATA;
				end
				uart_pkg::ST_DATA: begin
					cnt <= cnt + 1'b1;
					if (bit_end) begin
						if (idx == uart_pkg::IDX_LAST)
							state <= uart_pkg::ST_STOP;
						else
							idx <= idx + 1'b1;
					end
				end
				uart_pkg::ST_STOP: begin
					cnt <= cnt + 1'b1;
					if (bit_end)
						state <= uart_pkg::ST_IDLE;	// busy drops here
				end
				default: state <= uart_pkg::ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == uart_pkg::ST_IDLE && tx_start)
			shift <= tx_data;	// latch byte
		else if (state == uart_pkg::ST_DATA && bit_end)
			shift <= {1'b0, shift[uart_pkg::DATA_BITS-1:1]};	// next bit out lsb first
	end

	// the register block must hold off while a frame is going out
	a_no_start_when_busy: assert property (@(posedge clk) disable iff (!reset_n)
		tx_start |-> !tx_busy);

endmodule

/* src/uart_apb_regs.sv */
`timescale 1ns/100ps

module uart_apb_regs (
	input  logic clk,
	input  logic reset_n,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [2:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input  logic rx_valid,
	input  uart_pkg::byte_t rx_data,
	output logic tx_start,
	output uart_pkg::byte_t tx_data,
	input  logic tx_busy,
	output logic irq,
	input  logic irq_ack
);

	uart_pkg::reg_addr_e addr;
	logic access;	// apb access phase
	logic wr_tx;
	logic rd_rx;
	uart_pkg::byte_t rx_byte;
	logic rx_flag;
	logic rx_ovr;

	assign addr = uart_pkg::reg_addr_e'(paddr[2]);	// word select
	assign access = psel && penable;
	assign wr_tx = access && pwrite && (addr == uart_pkg::REG_TXDATA);
	assign rd_rx = access && !pwrite && (addr == uart_pkg::REG_RXDATA);

	assign pready = 1'b1;	// no wait states
	assign pslverr = wr_tx && tx_busy;	// byte dropped

	// read mux is zero when not reading
	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			case (addr)
				uart_pkg::REG_RXDATA: prdata = {22'b0, rx_ovr, rx_flag, rx_byte};
				uart_pkg::REG_TXDATA: prdata = {23'b0, tx_busy, 8'b0};
				default: prdata = '0;
			endcase
		end
	end

	// receive side
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			rx_byte <= '0;
			rx_flag <= 1'b0;
			rx_ovr <= 1'b0;
		end else begin
			if (rd_rx) begin	// read clears both flags
				rx_flag <= 1'b0;
				rx_ovr <= 1'b0;
			end
			if (rx_valid) begin	// a new byte wins over a read in the same cycle
				rx_byte <= rx_data;
				rx_flag <= 1'b1;
				if (rx_flag && !rd_rx)
					rx_ovr <= 1'b1;	// old byte lost
			end
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			irq <= 1'b0;
		else if (rx_valid)
			irq <= 1'b1;
		else if (irq_ack)
			irq <= 1'b0;	// rx_flag stays until read
	end

	// transmit launch
	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n)
			tx_start <= 1'b0;
		else
			tx_start <= wr_tx && !tx_busy;
	end

	always_ff @(posedge clk) begin
		if (wr_tx && !tx_busy)
			tx_data <= pwdata[uart_pkg::DATA_BITS-1:0];
	end

	a_penable_needs_psel: assert property (@(posedge clk) disable iff (!reset_n)
		penable |-> psel);

	// irq only comes from a received byte
	a_irq_after_rx: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(irq) |-> $past(rx_valid));

endmodule

/* src/uart_top.sv */
`timescale 1ns/100ps

module uart_top (
	input  logic clk,
	input  logic reset_n,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [2:0] paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	input  logic rxd,
	output logic txd,
	output logic irq,
	input  logic irq_ack
);

	logic rx_valid;
	uart_pkg::byte_t rx_data;
	logic tx_start;
	uart_pkg::byte_t tx_data;
	logic tx_busy;

	uart_apb_regs u_regs (
		.clk(clk),
		.reset_n(reset_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.tx_busy(tx_busy),
		.irq(irq),
		.irq_ack(irq_ack)
	);

	uart_rx u_rx (
		.clk(clk),
		.reset_n(reset_n),
		.rxd(rxd),
		.rx_valid(rx_valid),
		.rx_data(rx_data)
	);

	uart_tx u_tx (
		.clk(clk),
		.reset_n(reset_n),
		.tx_start(tx_start),
		.tx_data(tx_data),
		.tx_busy(tx_busy),
		.txd(txd)
	);

endmodule

/* tests/uart_tb.sv */
`timescale 1ns/100ps

module uart_tb;

	localparam int CLK_NS = 20;
	localparam int FRAME_NS = 10 * uart_pkg::CLKS_PER_BIT * CLK_NS;
	localparam int RX_FLAG = 8;	// REG_RXDATA fields above the byte
	localparam int OVR_FLAG = 9;
	localparam int BUSY_FLAG = 8;	// REG_TXDATA

	logic clk;
	logic reset_n = 1'b0;
	logic psel = 1'b0;
	logic penable = 1'b0;
	logic pwrite = 1'b0;
	logic [2:0] paddr = '0;
	logic [31:0] pwdata = '0;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic rxd = 1'b1;	// line idles high
	logic txd;
	logic irq;
	logic irq_ack = 1'b0;
	logic [31:0] rng = 32'h4c03;	// xorshift state
	string stim_q[$];
	int n_ops = 0;

	uart_top uut (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	task automatic abort_run();
		$display("Simulation FAILED");
		$fatal(1, "run stopped at %0t ns", $time);
	endtask

	task automatic check_byte(input string name, input uart_pkg::byte_t exp,
			input uart_pkg::byte_t act);
		if (act !== exp) begin
			$display("CHECK FAILED %s expected %h actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("CHECK FAILED %s expected %b actual %b", name, exp, act);
			abort_run();
		end
	endtask

	// setup cycle, then one access cycle
	task automatic apb_xfer(input logic wr, input uart_pkg::reg_addr_e addr,
			input uart_pkg::byte_t data, output logic [31:0] rdata, output logic err);
		@(posedge clk);
		rng = xorshift(rng);
		psel <= 1'b1;
		pwrite <= wr;
		paddr <= {addr, 2'b00};	// bit 2 picks the register
		pwdata <= {rng[23:0], data};	// filler above the byte
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);	// middle of the access cycle
		rdata = prdata;
		err = pslverr;
		check_flag("pready", 1'b1, pready);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic read_check(input string name, input uart_pkg::reg_addr_e addr,
			input uart_pkg::byte_t exp, input logic exp_8, input logic exp_9);
		logic [31:0] rd;
		logic err;
		int flag_bit;
		flag_bit = (addr == uart_pkg::REG_TXDATA) ? BUSY_FLAG : RX_FLAG;
		apb_xfer(1'b0, addr, 8'h00, rd, err);
		check_flag({name, " read pslverr"}, 1'b0, err);
		check_byte({name, " data byte"}, exp, rd[7:0]);
		check_flag({name, " bit 8"}, exp_8, rd[flag_bit]);
		check_flag({name, " bit 9"}, exp_9, rd[OVR_FLAG]);
		check_flag({name, " upper bits set"}, 1'b0, |rd[31:OVR_FLAG+1]);
	endtask

	// 8N1 frame on rxd, then wait for the interrupt
	task automatic receive_byte(input uart_pkg::byte_t data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};	// stop, data, start
		@(posedge clk);
		for (int i = 0; i < 10; i++) begin
			rxd <= frame[i];
			repeat (uart_pkg::CLKS_PER_BIT) @(posedge clk);
		end
		@(negedge clk);
		while (irq !== 1'b1)
			@(negedge clk);
	endtask

	task automatic collect_frame(input string name, output uart_pkg::byte_t data);
		@(negedge clk);
		while (txd !== 1'b0)
			@(negedge clk);
		repeat (uart_pkg::CLKS_PER_BIT / 2) @(negedge clk);	// mid start bit
		for (int i = 0; i < uart_pkg::DATA_BITS; i++) begin
			repeat (uart_pkg::CLKS_PER_BIT) @(negedge clk);
			data[i] = txd;	// lsb first
		end
		repeat (uart_pkg::CLKS_PER_BIT) @(negedge clk);
		check_flag({name, " stop bit"}, 1'b1, txd);
	endtask

	task automatic ack_irq();
		@(posedge clk);
		irq_ack <= 1'b1;
		@(posedge clk);
		irq_ack <= 1'b0;
		@(negedge clk);
	endtask

	task automatic run_test(input string line);
		logic [7:0] op;
		string name;
		uart_pkg::byte_t d0;
		uart_pkg::byte_t d1;
		uart_pkg::byte_t exp_b;
		logic fa;
		logic fb;
		logic [31:0] rd;
		logic err;
		uart_pkg::byte_t got;
		if ($sscanf(line, "%c %s %h %h %h %h %h", op, name, d0, d1, exp_b, fa, fb) != 7) begin
			$display("malformed stimulus line: %s", line);
			abort_run();
		end
		case (op)
			"R", "O", "I": begin
				receive_byte(d0);
				if (op == "O") begin
					ack_irq();	// irq rises again with the second byte
					receive_byte(d1);
				end
				if (op == "I") begin
					ack_irq();
					check_flag({name, " irq after ack"}, fa, irq);
					read_check(name, uart_pkg::REG_RXDATA, exp_b, fb, 1'b0);
				end else begin
					read_check(name, uart_pkg::REG_RXDATA, exp_b, fa, fb);
					read_check({name, " reread"}, uart_pkg::REG_RXDATA, exp_b, 1'b0, 1'b0);
					ack_irq();
				end
			end
			"T", "B": begin
				apb_xfer(1'b1, uart_pkg::REG_TXDATA, d0, rd, err);
				check_flag({name, " first write pslverr"}, 1'b0, err);
				fork
					collect_frame(name, got);
					if (op == "T") begin
						read_check({name, " during"}, uart_pkg::REG_TXDATA, 8'h00, fa, 1'b0);
					end else begin
						apb_xfer(1'b1, uart_pkg::REG_TXDATA, d1, rd, err);
						check_flag({name, " pslverr"}, fa, err);
					end
				join
				check_byte({name, " txd byte"}, exp_b, got);
				repeat (uart_pkg::CLKS_PER_BIT) @(posedge clk);	// past the stop bit
				read_check({name, " after"}, uart_pkg::REG_TXDATA, 8'h00, fb, 1'b0);
			end
			default: begin
				$display("unknown operation %c in the stimulus file", op);
				abort_run();
			end
		endcase
	endtask

	initial begin
		int fd;
		string line;
		fd = $fopen("tests/uart_stim.txt", "r");
		if (fd == 0) begin
			$display("cannot open tests/uart_stim.txt");
			abort_run();
		end
		while ($fgets(line, fd) > 0) begin
			if (line.len() > 1 && line[0] != "#")
				stim_q.push_back(line);
		end
		$fclose(fd);
		if (stim_q.size() == 0) begin
			$display("no operations in tests/uart_stim.txt");
			abort_run();
		end
		n_ops = stim_q.size();
		repeat (3) @(posedge clk);
		reset_n <= 1'b1;
		@(negedge clk);
		check_flag("reset txd", 1'b1, txd);
		check_flag("reset irq", 1'b0, irq);
		read_check("reset rx", uart_pkg::REG_RXDATA, 8'h00, 1'b0, 1'b0);
		read_check("reset tx", uart_pkg::REG_TXDATA, 8'h00, 1'b0, 1'b0);
		foreach (stim_q[k])
			run_test(stim_q[k]);
		$display("Simulation PASSED");
		$finish;
	end

	// four frame times per operation, plus slack for reset
	initial begin
		wait (n_ops > 0);
		#(n_ops * 4 * FRAME_NS + 100 * CLK_NS);
		$display("timeout: tests did not finish");
		abort_run();
	end

endmodule

/* tests/uart_stim.txt */
# op name d0 d1 exp_byte flag_a flag_b, values in hex, d1 used by O and B only
# flags: R/O rx+overrun, T busy during+after, B pslverr+busy after, I irq+rx flag after ack
R rx_a5 a5 00 a5 1 0
R rx_3c 3c 00 3c 1 0
R rx_ff ff 00 ff 1 0
O ovr_12_34 12 34 34 1 1
O ovr_80_01 80 01 01 1 1
T tx_55 55 00 55 1 0
T tx_c3 c3 00 c3 1 0
B busy_96 96 69 96 1 0
B busy_0f 0f f0 0f 1 0
I ack_5a 5a 00 5a 0 1
I ack_e7 e7 00 e7 0 1

/* all.f */
src/uart_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/uart_apb_regs.sv
src/uart_top.sv
tests/uart_tb.sv

/* Bender.yml */
package:
  name: uart_apb

sources:
  - src/uart_pkg.sv
  - src/uart_rx.sv
  - src/uart_tx.sv
  - src/uart_apb_regs.sv
  - src/uart_top.sv
  - target: test
    files:
      - tests/uart_tb.sv
